/* rtl/audio_mix_pkg.sv */
package audio_mix_pkg;

	//////////////////////////////////////////////////
	// sample formats
	//////////////////////////////////////////////////

	// one audio sample
	// signed two's complement at the mixer output
	typedef logic [15:0] sample_t;

	// headroom format
	// holds the sum of two samples without overflow
	typedef logic signed [16:0] wide_t;

	//////////////////////////////////////////////////
	// control fields
	//////////////////////////////////////////////////

	// bit 4 mutes the output
	// low four bits give the right shift count
	typedef logic [4:0] att_t;

	// crossfeed amount
	// 0 none, 1 light, 2 medium, 3 full mono
	typedef logic [1:0] mix_sel_t;

	// complete mixer setting
	typedef struct packed {
		att_t     att;
		mix_sel_t mix;
		logic     is_signed;
	} mix_cfg_t;

	//////////////////////////////////////////////////
	// stereo pairs
	//////////////////////////////////////////////////

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// same pair in headroom format
	typedef struct packed {
		wide_t left;
		wide_t right;
	} stereo_wide_t;

endpackage

/* rtl/core_deglitch.sv */
module core_deglitch (
	input  logic                   clk,
	input  logic                   resetd,
	input  audio_mix_pkg::stereo_t i_core,
	output audio_mix_pkg::stereo_t o_core
);

	//////////////////////////////////////////////////
	// delay line
	//////////////////////////////////////////////////

	// d1 is the newest tap
	audio_mix_pkg::stereo_t tap_d1;
	audio_mix_pkg::stereo_t tap_d2;
	audio_mix_pkg::stereo_t tap_d3;

	always_ff @(posedge clk) begin
		if (resetd) begin
			tap_d1 <= '0;
			tap_d2 <= '0;
			tap_d3 <= '0;
		end else begin
			tap_d1 <= i_core;
			tap_d2 <= tap_d1;
			tap_d3 <= tap_d2;
		end
	end

	//////////////////////////////////////////////////
	// held sample
	//////////////////////////////////////////////////

	// update only once the two oldest taps agree
	// so a one cycle spike never gets through
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_core <= '0;
		end else begin
			if (tap_d2.left == tap_d3.left) begin
				o_core.left <= tap_d2.left;
			end
			// channels settle on their own
			if (tap_d2.right == tap_d3.right) begin
				o_core.right <= tap_d2.right;
			end
		end
	end

endmodule

/* rtl/pcm_sum.sv */
module pcm_sum (
	input  logic                        clk,
	input  logic                        resetd,
	input  audio_mix_pkg::stereo_t      i_core,
	input  audio_mix_pkg::stereo_t      i_linux,
	input  logic                        i_is_signed,
	output audio_mix_pkg::stereo_wide_t o_sum
);

	// core sample in headroom format
	audio_mix_pkg::stereo_wide_t core_wide;

	// signed samples keep their value
	// unsigned ones are halved so they fit beside the host sample
	function automatic audio_mix_pkg::wide_t core_to_wide(
		input audio_mix_pkg::sample_t smp,
		input logic                   is_signed
	);
		if (is_signed) begin
			return {smp[15], smp};
		end
		return {2'b00, smp[15:1]};
	endfunction

	// host PCM is always signed
	function automatic audio_mix_pkg::wide_t host_to_wide(
		input audio_mix_pkg::sample_t smp
	);
		return {smp[15], smp};
	endfunction

	//////////////////////////////////////////////////
	// format stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_wide <= '0;
		end else begin
			core_wide.left  <= core_to_wide(i_core.left, i_is_signed);
			core_wide.right <= core_to_wide(i_core.right, i_is_signed);
		end
	end

	//////////////////////////////////////////////////
	// sum stage
	//////////////////////////////////////////////////

	// host sample enters here, one cycle after the core sample
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
		end else begin
			o_sum.left  <= core_wide.left + host_to_wide(i_linux.left);
			o_sum.right <= core_wide.right + host_to_wide(i_linux.right);
		end
	end

endmodule

/* rtl/cross_blend.sv */
module cross_blend (
	input  logic                        clk,
	input  logic                        resetd,
	input  audio_mix_pkg::stereo_wide_t i_sum,
	input  audio_mix_pkg::mix_sel_t     i_mix,
	output audio_mix_pkg::stereo_wide_t o_blend
);

	//////////////////////////////////////////////////
	// pre-mix
	//////////////////////////////////////////////////

	// half scale copy of each channel
	// the other channel reads it one sample later
	audio_mix_pkg::stereo_t pre_mix;

	always_ff @(posedge clk) begin
		if (resetd) begin
			pre_mix <= '0;
		end else begin
			// arithmetic shift by one then keep 16 bits
			pre_mix.left  <= i_sum.left[16:1];
			pre_mix.right <= i_sum.right[16:1];
		end
	end

	//////////////////////////////////////////////////
	// crossfeed
	//////////////////////////////////////////////////

	// own sum blended with the opposite pre-mix
	// everything wraps in 17 bits
	function automatic audio_mix_pkg::wide_t blend_one(
		input audio_mix_pkg::wide_t    sum,
		input audio_mix_pkg::sample_t  pre_other,
		input audio_mix_pkg::mix_sel_t mix
	);
		audio_mix_pkg::wide_t pre_wide;
		audio_mix_pkg::wide_t res;

		pre_wide = {pre_other[15], pre_other};
		case (mix)
			2'd0: begin
				// straight through
				res = sum;
			end
			2'd1: begin
				// light, 7/8 own plus 1/8 other
				res = sum - (sum >>> 3) + (pre_wide >>> 2);
			end
			2'd2: begin
				// medium, 3/4 own plus 1/4 other
				res = sum - (sum >>> 2) + (pre_wide >>> 1);
			end
			default: begin
				// full mono
				res = (sum >>> 1) + pre_wide;
			end
		endcase
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_blend <= '0;
		end else begin
			o_blend.left  <= blend_one(i_sum.left, pre_mix.right, i_mix);
			o_blend.right <= blend_one(i_sum.right, pre_mix.left, i_mix);
		end
	end

endmodule

/* rtl/volume_clamp.sv */
module volume_clamp (
	input  logic                        clk,
	input  logic                        resetd,
	input  audio_mix_pkg::stereo_wide_t i_blend,
	input  audio_mix_pkg::att_t         i_att,
	output audio_mix_pkg::stereo_t      o_out
);

	// attenuated sample still in headroom format
	audio_mix_pkg::stereo_wide_t att_q;

	// mute wins over any shift count
	function automatic audio_mix_pkg::wide_t attenuate(
		input audio_mix_pkg::wide_t v,
		input audio_mix_pkg::att_t  att
	);
		if (att[4]) begin
			return '0;
		end
		return v >>> att[3:0];
	endfunction

	// saturate when the top two bits disagree
	function automatic audio_mix_pkg::sample_t clamp16(
		input audio_mix_pkg::wide_t v
	);
		if (v[16] != v[15]) begin
			// sign picks 0x7fff or 0x8000
			return {v[16], {15{v[15]}}};
		end
		return v[15:0];
	endfunction

	//////////////////////////////////////////////////
	// attenuation stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_q <= '0;
		end else begin
			att_q.left  <= attenuate(i_blend.left, i_att);
			att_q.right <= attenuate(i_blend.right, i_att);
		end
	end

	//////////////////////////////////////////////////
	// clamp stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_out <= '0;
		end else begin
			o_out.left  <= clamp16(att_q.left);
			o_out.right <= clamp16(att_q.right);
		end
	end

endmodule

/* rtl/audio_mixer.sv */
module audio_mixer (
	input  logic                     clk,
	input  logic                     resetd,
	input  audio_mix_pkg::mix_cfg_t  i_cfg,
	input  audio_mix_pkg::stereo_t   i_core,
	input  audio_mix_pkg::stereo_t   i_linux,
	output audio_mix_pkg::stereo_t   o_out
);

	// core sample after glitch removal
	audio_mix_pkg::stereo_t      core_clean;

	// core plus host in headroom format
	audio_mix_pkg::stereo_wide_t mix_sum;

	// after crossfeed
	audio_mix_pkg::stereo_wide_t mix_blend;

	//////////////////////////////////////////////////
	// core input
	//////////////////////////////////////////////////

	// 4 cycles
	core_deglitch core_deglitch_i (
		.clk    (clk),
		.resetd (resetd),
		.i_core (i_core),
		.o_core (core_clean)
	);

	//////////////////////////////////////////////////
	// mixing
	//////////////////////////////////////////////////

	// 2 cycles, host sample taken on the second
	pcm_sum pcm_sum_i (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (core_clean),
		.i_linux     (i_linux),
		.i_is_signed (i_cfg.is_signed),
		.o_sum       (mix_sum)
	);

	// 1 cycle
	cross_blend cross_blend_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_sum   (mix_sum),
		.i_mix   (i_cfg.mix),
		.o_blend (mix_blend)
	);

	//////////////////////////////////////////////////
	// output
	//////////////////////////////////////////////////

	// 2 cycles
	// core to output is 9 cycles and host to output is 4
	volume_clamp volume_clamp_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_blend (mix_blend),
		.i_att   (i_cfg.att),
		.o_out   (o_out)
	);

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
	output logic o_clk,
	output logic o_resetd
);

	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	localparam int HALF_PERIOD = 20;

	initial begin
		o_clk = 1'b0;
		forever begin
			#HALF_PERIOD o_clk = ~o_clk;
		end
	end

	// reset held over the first five rising edges
	initial begin
		o_resetd = 1'b1;
		repeat (5) @(posedge o_clk);
		#2 o_resetd = 1'b0;
	end

endmodule

/* sim/audio_mixer_tb.sv */
module audio_mixer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DELAY = 3;
	localparam int EDGE_LIMIT  = 60;
	localparam int SETTLE      = 11;

	typedef struct packed {
		audio_mix_pkg::mix_cfg_t cfg;
		audio_mix_pkg::stereo_t  core;
		audio_mix_pkg::stereo_t  linux;
		audio_mix_pkg::stereo_t  exp_out;
	} test_row_t;

	logic                    clk;
	logic                    resetd;
	audio_mix_pkg::mix_cfg_t cfg;
	audio_mix_pkg::stereo_t  core_in;
	audio_mix_pkg::stereo_t  host_in;
	audio_mix_pkg::stereo_t  dut_out;
	test_row_t               rows[$];

	tb_clock_gen clock_gen_i (
		.o_clk    (clk),
		.o_resetd (resetd)
	);

	audio_mixer dut_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_cfg   (cfg),
		.i_core  (core_in),
		.i_linux (host_in),
		.o_out   (dut_out)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic int core_value(input audio_mix_pkg::sample_t s, input logic is_signed);
		int v;
		if (is_signed) begin
			v = $signed(s);
		end else begin
			// unsigned core samples are halved
			v = s;
			v = v / 2;
		end
		return v;
	endfunction

	function automatic int wrap17(input int v);
		int w;
		w = v & 32'h1ffff;
		if (w >= 65536) begin
			w = w - 131072;
		end
		return w;
	endfunction

	function automatic int blend_rule(input int own, input int pre_other,
			input audio_mix_pkg::mix_sel_t mix);
		int v;
		case (mix)
			2'd0: v = own;
			2'd1: v = own - (own >>> 3) + (pre_other >>> 2);
			2'd2: v = own - (own >>> 2) + (pre_other >>> 1);
			default: v = (own >>> 1) + pre_other;
		endcase
		return wrap17(v);
	endfunction

	function automatic audio_mix_pkg::sample_t level_model(input int v,
			input audio_mix_pkg::att_t att);
		int a;
		if (att[4]) begin
			return 16'h0000;
		end
		a = v >>> att[3:0];
		if (a > 32767) begin
			return 16'h7fff;
		end
		if (a < -32768) begin
			return 16'h8000;
		end
		return a[15:0];
	endfunction

	function automatic audio_mix_pkg::stereo_t model_pair(input audio_mix_pkg::mix_cfg_t c,
			input audio_mix_pkg::stereo_t core, input audio_mix_pkg::stereo_t host);
		int                     sum_l;
		int                     sum_r;
		audio_mix_pkg::stereo_t res;
		sum_l = core_value(core.left, c.is_signed) + core_value(host.left, 1'b1);
		sum_r = core_value(core.right, c.is_signed) + core_value(host.right, 1'b1);
		// steady pre-mix is half the other channel's sum
		res.left  = level_model(blend_rule(sum_l, sum_r >>> 1, c.mix), c.att);
		res.right = level_model(blend_rule(sum_r, sum_l >>> 1, c.mix), c.att);
		return res;
	endfunction

	//////////////////////////////////////////////////
	// table helpers
	//////////////////////////////////////////////////

	function automatic audio_mix_pkg::mix_cfg_t make_cfg(input audio_mix_pkg::att_t att,
			input audio_mix_pkg::mix_sel_t mix, input logic is_signed);
		audio_mix_pkg::mix_cfg_t c;
		c.att       = att;
		c.mix       = mix;
		c.is_signed = is_signed;
		return c;
	endfunction

	function automatic audio_mix_pkg::stereo_t make_pair(input audio_mix_pkg::sample_t l,
			input audio_mix_pkg::sample_t r);
		audio_mix_pkg::stereo_t p;
		p.left  = l;
		p.right = r;
		return p;
	endfunction

	function automatic test_row_t make_row(input audio_mix_pkg::mix_cfg_t c,
			input audio_mix_pkg::stereo_t core, input audio_mix_pkg::stereo_t host);
		test_row_t r;
		r.cfg     = c;
		r.core    = core;
		r.linux   = host;
		r.exp_out = model_pair(c, core, host);
		return r;
	endfunction

	//////////////////////////////////////////////////
	// waits and checks
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	// polls the clock so a stopped clock cannot hang the run
	task automatic wait_rise();
		int waited;
		waited = 0;
		while (clk === 1'b1 && waited < EDGE_LIMIT) begin
			#1 waited++;
		end
		while (clk !== 1'b1 && waited < EDGE_LIMIT) begin
			#1 waited++;
		end
		if (waited >= EDGE_LIMIT) begin
			stop_with_failure("timed out waiting for a rising edge of clk");
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			wait_rise();
		end
		#DRIVE_DELAY;
	endtask

	task automatic check_stereo(input audio_mix_pkg::stereo_t got,
			input audio_mix_pkg::stereo_t exp, input string name);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_sample(input audio_mix_pkg::sample_t got,
			input audio_mix_pkg::sample_t exp, input string name);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic apply_row(input test_row_t r);
		wait_cycles(1);
		cfg     = r.cfg;
		core_in = r.core;
		host_in = r.linux;
		wait_cycles(SETTLE);
		check_stereo(dut_out, r.exp_out, "o_out");
	endtask

	//////////////////////////////////////////////////
	// glitch rejection
	//////////////////////////////////////////////////

	task automatic glitch_test();
		test_row_t              base;
		test_row_t              moved;
		audio_mix_pkg::stereo_t spike;
		logic                   seen;
		base  = make_row(make_cfg(5'd0, 2'd0, 1'b1), make_pair(16'h1234, 16'h0800), '0);
		spike = make_pair(16'h4321, 16'h0800);
		moved = make_row(base.cfg, spike, '0);
		apply_row(base);
		// one cycle spike on the left channel
		wait_cycles(1);
		core_in = spike;
		wait_cycles(1);
		core_in = base.core;
		for (int i = 0; i < 12; i++) begin
			wait_cycles(1);
			check_sample(dut_out.left, base.exp_out.left, "o_out.left");
		end
		// two cycle change must get through
		core_in = spike;
		wait_cycles(2);
		core_in = base.core;
		seen = 1'b0;
		for (int i = 0; i < 12; i++) begin
			wait_cycles(1);
			if (dut_out.left === moved.exp_out.left) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			stop_with_failure("a two-cycle change on i_core never reached o_out.left");
		end
		apply_row(moved);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int                     resets;
		audio_mix_pkg::stereo_t dist_core;
		audio_mix_pkg::stereo_t dist_host;
		audio_mix_pkg::mix_cfg_t rnd_cfg;
		audio_mix_pkg::stereo_t rnd_core;
		audio_mix_pkg::stereo_t rnd_host;

		cfg     = '0;
		core_in = '0;
		host_in = '0;
		void'($urandom(32'h46fd_9bb0));

		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1), '0, '0));
		// format conversion
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1),
			make_pair(16'h1000, 16'hf000), make_pair(16'h0234, 16'h0100)));
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1),
			make_pair(16'h7000, 16'h9000), make_pair(16'h2000, 16'hc000)));
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b0),
			make_pair(16'hffff, 16'h8000), make_pair(16'h0000, 16'h1000)));
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b0),
			make_pair(16'h0002, 16'h2000), make_pair(16'hfff0, 16'h8000)));
		// crossfeed modes
		dist_core = make_pair(16'h3000, 16'he800);
		dist_host = make_pair(16'h0400, 16'h0100);
		for (int m = 0; m < 4; m++) begin
			rows.push_back(make_row(make_cfg(5'd0, m[1:0], 1'b1), dist_core, dist_host));
		end
		// attenuation then mute
		dist_core = make_pair(16'h5a5a, 16'ha5a5);
		dist_host = make_pair(16'h0101, 16'hff00);
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1), dist_core, dist_host));
		rows.push_back(make_row(make_cfg(5'd1, 2'd0, 1'b1), dist_core, dist_host));
		rows.push_back(make_row(make_cfg(5'd7, 2'd0, 1'b1), dist_core, dist_host));
		rows.push_back(make_row(make_cfg(5'd15, 2'd0, 1'b1), dist_core, dist_host));
		rows.push_back(make_row(make_cfg(5'h10, 2'd2, 1'b1), dist_core, dist_host));
		rows.push_back(make_row(make_cfg(5'h1f, 2'd1, 1'b1), dist_core, dist_host));
		// full scale in both sources
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1),
			make_pair(16'h7fff, 16'h8000), make_pair(16'h7fff, 16'h8000)));
		rows.push_back(make_row(make_cfg(5'd0, 2'd0, 1'b1),
			make_pair(16'h8000, 16'h7fff), make_pair(16'h8000, 16'h7fff)));
		for (int i = 0; i < 8; i++) begin
			rnd_cfg  = 8'($urandom);
			rnd_core = $urandom;
			rnd_host = $urandom;
			rows.push_back(make_row(rnd_cfg, rnd_core, rnd_host));
		end

		resets = 0;
		while (resetd !== 1'b0) begin
			if (resets >= 20) begin
				stop_with_failure("resetd was never released by the clock generator");
			end
			wait_rise();
			resets++;
		end
		#DRIVE_DELAY;
		check_stereo(dut_out, '0, "o_out");

		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		glitch_test();

		$display("Done: no errors");
		$finish;
	end

endmodule

/* all.f */
rtl/audio_mix_pkg.sv
rtl/core_deglitch.sv
rtl/pcm_sum.sv
rtl/cross_blend.sv
rtl/volume_clamp.sv
rtl/audio_mixer.sv
sim/tb_clock_gen.sv
sim/audio_mixer_tb.sv

/* Bender.yml */
package:
  name: audio_mixer

sources:
  # package first, then the stages, then the top level
  - rtl/audio_mix_pkg.sv
  - rtl/core_deglitch.sv
  - rtl/pcm_sum.sv
  - rtl/cross_blend.sv
  - rtl/volume_clamp.sv
  - rtl/audio_mixer.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/audio_mixer_tb.sv
